// File: compile.f
rs_pkg.sv
psel_gen.sv
rs_dispatch.sv
rs_entry_array.sv
rs_issue_select.sv
rs_top.sv
rs_tb.sv

// File: psel_gen.sv
`timescale 1ns/100ps
`default_nettype none

// grants the REQS lowest set bits of req, one per row
module psel_gen #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  wire logic [WIDTH-1:0]           req,
    output      logic [REQS-1:0][WIDTH-1:0] gnt_bus
);

    logic [WIDTH-1:0] remaining;
    logic             found;

    always_comb begin
        remaining = req;
        found     = 1'b0;
        gnt_bus   = '0;
        for (int r = 0; r < REQS; r++) begin
            found = 1'b0;
            // lowest remaining request wins this row
            for (int i = 0; i < WIDTH; i++) begin
                if (remaining[i] && !found) begin
                    gnt_bus[r][i] = 1'b1;
                    remaining[i]  = 1'b0;
                    found         = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rs_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module rs_dispatch (
    input  wire logic                                                  clock,
    input  wire logic                                                  reset,
    input  wire logic                                                  dispatch_valid,
    input  wire rs_pkg::dispatch_packet_t [rs_pkg::dispatch_width-1:0] dispatch_bundle,
    output      logic                                                  dispatch_ready,
    input  wire rs_pkg::br_resolve_t                                   br_resolve,
    input  wire logic [rs_pkg::rs_depth-1:0]                           free_entries,
    output      logic [rs_pkg::dispatch_width-1:0][rs_pkg::rs_depth-1:0] write_enable_bus,
    output      rs_pkg::rs_entry_t [rs_pkg::dispatch_width-1:0]        write_entries
);

    logic [rs_pkg::dispatch_width-1:0][rs_pkg::rs_depth-1:0] free_gnt_bus;
    rs_pkg::br_mask_t br_mask_q;
    rs_pkg::br_mask_t br_mask_next;
    rs_pkg::br_mask_t lane_mask;
    rs_pkg::br_mask_t resolved;
    logic             accept;

    // lowest free slots, one per lane
    psel_gen #(
        .WIDTH(rs_pkg::rs_depth),
        .REQS (rs_pkg::dispatch_width)
    ) free_psel (
        .req    (free_entries),
        .gnt_bus(free_gnt_bus)
    );

    assign dispatch_ready = ($countones(free_entries) >= rs_pkg::dispatch_width);
    assign accept         = dispatch_valid && dispatch_ready;
    assign resolved       = br_resolve.valid ? br_resolve.br_id : '0;

    always_comb begin
        lane_mask = br_mask_q;
        for (int l = 0; l < rs_pkg::dispatch_width; l++) begin
            write_enable_bus[l] = (accept && dispatch_bundle[l].valid) ? free_gnt_bus[l] : '0;
            write_entries[l].valid    = dispatch_bundle[l].valid;
            write_entries[l].fu_class = dispatch_bundle[l].fu_class;
            write_entries[l].dest     = dispatch_bundle[l].dest;
            write_entries[l].src1     = dispatch_bundle[l].src1;
            write_entries[l].src2     = dispatch_bundle[l].src2;
            write_entries[l].seq      = dispatch_bundle[l].seq;
            // resolved bit never reaches a new entry
            write_entries[l].br_mask  = lane_mask & ~resolved;
            // later lanes depend on a branch opened here
            if (dispatch_bundle[l].valid && dispatch_bundle[l].new_branch) begin
                lane_mask = lane_mask | dispatch_bundle[l].br_id;
            end
        end
        br_mask_next = (accept ? lane_mask : br_mask_q) & ~resolved;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            br_mask_q <= '0;
        end else begin
            br_mask_q <= br_mask_next;
        end
    end

endmodule

`default_nettype wire

// File: rs_entry_array.sv
`timescale 1ns/100ps
`default_nettype none

module rs_entry_array (
    input  wire logic                                                   clock,
    input  wire logic                                                   reset,
    input  wire logic [rs_pkg::dispatch_width-1:0][rs_pkg::rs_depth-1:0] write_enable_bus,
    input  wire rs_pkg::rs_entry_t [rs_pkg::dispatch_width-1:0]         write_entries,
    input  wire rs_pkg::cdb_packet_t [rs_pkg::cdb_width-1:0]            cdb,
    input  wire rs_pkg::br_resolve_t                                    br_resolve,
    input  wire logic [rs_pkg::rs_depth-1:0]                            issued_entries,
    output      logic [rs_pkg::rs_depth-1:0]                            free_entries,
    output      logic [rs_pkg::rs_depth-1:0]                            alu_req,
    output      logic [rs_pkg::rs_depth-1:0]                            mult_req,
    output      rs_pkg::rs_entry_t [rs_pkg::rs_depth-1:0]               entries
);

    rs_pkg::rs_entry_t [rs_pkg::rs_depth-1:0] entries_next;
    logic [rs_pkg::rs_depth-1:0] squash_hit;
    logic [rs_pkg::rs_depth-1:0] entry_ready;
    rs_pkg::br_mask_t            clear_mask;

    // source goes ready when its tag is on the bus
    function automatic rs_pkg::src_operand_t wake(
        input rs_pkg::src_operand_t                     src,
        input rs_pkg::cdb_packet_t [rs_pkg::cdb_width-1:0] bus
    );
        rs_pkg::src_operand_t res;
        res = src;
        for (int c = 0; c < rs_pkg::cdb_width; c++) begin
            if (bus[c].valid && bus[c].tag == src.tag) begin
                res.ready = 1'b1;
            end
        end
        return res;
    endfunction

    always_comb begin
        clear_mask = '0;
        if (br_resolve.valid && !br_resolve.squash) begin
            clear_mask = br_resolve.br_id;
        end

        for (int i = 0; i < rs_pkg::rs_depth; i++) begin
            squash_hit[i] = br_resolve.valid && br_resolve.squash && entries[i].valid
                            && ((entries[i].br_mask & br_resolve.br_id) != '0);
            entry_ready[i] = entries[i].valid && entries[i].src1.ready
                             && entries[i].src2.ready && !squash_hit[i];
            alu_req[i]      = entry_ready[i] && (entries[i].fu_class == rs_pkg::class_alu);
            mult_req[i]     = entry_ready[i] && (entries[i].fu_class == rs_pkg::class_mult);
            free_entries[i] = !entries[i].valid;

            ////////////////////////////////////////////////////////////////////
            // next state of entry i
            ////////////////////////////////////////////////////////////////////
            entries_next[i]         = entries[i];
            entries_next[i].br_mask = entries[i].br_mask & ~clear_mask;
            entries_next[i].src1    = wake(entries[i].src1, cdb);
            entries_next[i].src2    = wake(entries[i].src2, cdb);
            if (issued_entries[i] || squash_hit[i]) begin
                entries_next[i].valid = 1'b0;
            end

            // new write, woken by this cycle's broadcasts too
            for (int l = 0; l < rs_pkg::dispatch_width; l++) begin
                if (write_enable_bus[l][i]) begin
                    entries_next[i]      = write_entries[l];
                    entries_next[i].src1 = wake(write_entries[l].src1, cdb);
                    entries_next[i].src2 = wake(write_entries[l].src2, cdb);
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rs_pkg::rs_depth; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            entries <= entries_next;
        end
    end

endmodule

`default_nettype wire

// File: rs_issue_select.sv
`timescale 1ns/100ps
`default_nettype none

// picks ready entries of one class onto free functional units
module rs_issue_select #(
    parameter int NUM_FU = 2
) (
    input  wire logic [rs_pkg::rs_depth-1:0]              inst_req,
    input  wire logic [NUM_FU-1:0]                        fu_ready,
    input  wire rs_pkg::rs_entry_t [rs_pkg::rs_depth-1:0] entries,
    output      logic [NUM_FU-1:0]                        issue_valid,
    output      rs_pkg::issue_packet_t [NUM_FU-1:0]       issue,
    output      logic [rs_pkg::rs_depth-1:0]              granted
);

    logic [NUM_FU-1:0][NUM_FU-1:0]           fu_gnt_bus;
    logic [NUM_FU-1:0][rs_pkg::rs_depth-1:0] inst_gnt_bus;

    function automatic rs_pkg::issue_packet_t to_issue(input rs_pkg::rs_entry_t e);
        rs_pkg::issue_packet_t p;
        p.dest    = e.dest;
        p.src1    = e.src1.tag;
        p.src2    = e.src2.tag;
        p.br_mask = e.br_mask;
        p.seq     = e.seq;
        return p;
    endfunction

    // busy units never make it into a row
    psel_gen #(
        .WIDTH(NUM_FU),
        .REQS (NUM_FU)
    ) fu_psel (
        .req    (fu_ready),
        .gnt_bus(fu_gnt_bus)
    );

    psel_gen #(
        .WIDTH(rs_pkg::rs_depth),
        .REQS (NUM_FU)
    ) inst_psel (
        .req    (inst_req),
        .gnt_bus(inst_gnt_bus)
    );

    always_comb begin
        issue_valid = '0;
        issue       = '0;
        granted     = '0;
        // n-th free unit takes the n-th oldest-index request
        for (int n = 0; n < NUM_FU; n++) begin
            if ((|inst_gnt_bus[n]) && (|fu_gnt_bus[n])) begin
                granted = granted | inst_gnt_bus[n];
                for (int f = 0; f < NUM_FU; f++) begin
                    if (fu_gnt_bus[n][f]) begin
                        issue_valid[f] = 1'b1;
                        for (int j = 0; j < rs_pkg::rs_depth; j++) begin
                            if (inst_gnt_bus[n][j]) begin
                                issue[f] = to_issue(entries[j]);
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rs_pkg.sv
`default_nettype none

package rs_pkg;

    //////////////////////////////////////////////////////////////////////
    // sizes
    //////////////////////////////////////////////////////////////////////

    localparam int rs_depth       = 8;
    localparam int dispatch_width = 2;
    localparam int cdb_width      = 2;
    localparam int num_alu        = 2;
    localparam int num_mult       = 1;
    localparam int preg_bits      = 6;
    localparam int br_bits        = 4;
    localparam int seq_bits       = 8;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [preg_bits-1:0] preg_tag_t;
    // one bit per unresolved branch
    typedef logic [br_bits-1:0]   br_mask_t;

    typedef enum logic {
        class_alu,
        class_mult
    } fu_class_t;

    typedef struct packed {
        preg_tag_t tag;
        logic      ready;
    } src_operand_t;

    typedef struct packed {
        logic                valid;
        fu_class_t           fu_class;
        preg_tag_t           dest;
        src_operand_t        src1;
        src_operand_t        src2;
        logic                new_branch;
        br_mask_t            br_id;
        logic [seq_bits-1:0] seq;
    } dispatch_packet_t;

    typedef struct packed {
        logic                valid;
        fu_class_t           fu_class;
        preg_tag_t           dest;
        src_operand_t        src1;
        src_operand_t        src2;
        br_mask_t            br_mask;
        logic [seq_bits-1:0] seq;
    } rs_entry_t;

    // what a functional unit receives
    typedef struct packed {
        preg_tag_t           dest;
        preg_tag_t           src1;
        preg_tag_t           src2;
        br_mask_t            br_mask;
        logic [seq_bits-1:0] seq;
    } issue_packet_t;

    typedef struct packed {
        logic      valid;
        preg_tag_t tag;
    } cdb_packet_t;

    // squash = 0 means clear the bit
    typedef struct packed {
        logic     valid;
        logic     squash;
        br_mask_t br_id;
    } br_resolve_t;

endpackage

`default_nettype wire

// File: rs_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rs_tb;

    localparam int timeout_cycles = 2000;
    localparam int num_seq        = 2 ** rs_pkg::seq_bits;

    logic                                                  clock;
    logic                                                  reset;
    logic                                                  dispatch_valid;
    rs_pkg::dispatch_packet_t [rs_pkg::dispatch_width-1:0] dispatch_bundle;
    logic                                                  dispatch_ready;
    rs_pkg::cdb_packet_t [rs_pkg::cdb_width-1:0]           cdb;
    rs_pkg::br_resolve_t                                   br_resolve;
    logic [rs_pkg::num_alu-1:0]                            alu_ready;
    logic [rs_pkg::num_alu-1:0]                            issue_alu_valid;
    rs_pkg::issue_packet_t [rs_pkg::num_alu-1:0]           issue_alu;
    logic [rs_pkg::num_mult-1:0]                           mult_ready;
    logic [rs_pkg::num_mult-1:0]                           issue_mult_valid;
    rs_pkg::issue_packet_t [rs_pkg::num_mult-1:0]          issue_mult;

    // scoreboard, indexed by seq
    logic              live     [num_seq];
    rs_pkg::fu_class_t sb_class [num_seq];
    rs_pkg::preg_tag_t sb_dest  [num_seq];
    rs_pkg::preg_tag_t sb_tag1  [num_seq];
    rs_pkg::preg_tag_t sb_tag2  [num_seq];
    logic              sb_rdy1  [num_seq];
    logic              sb_rdy2  [num_seq];
    rs_pkg::br_mask_t  sb_mask  [num_seq];
    int                occ;
    int                cycles;
    logic [rs_pkg::seq_bits-1:0] next_seq;
    rs_pkg::br_mask_t  run_mask;
    logic              hold_busy;
    logic              random_busy;
    logic              cdb_hold;
    rs_pkg::preg_tag_t pending [$];

    rs_top rs_top_i (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch_bundle (dispatch_bundle),
        .dispatch_ready  (dispatch_ready),
        .cdb             (cdb),
        .br_resolve      (br_resolve),
        .alu_ready       (alu_ready),
        .issue_alu_valid (issue_alu_valid),
        .issue_alu       (issue_alu),
        .mult_ready      (mult_ready),
        .issue_mult_valid(issue_mult_valid),
        .issue_mult      (issue_mult)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // no unit may see valid while it is busy
    busy_units_idle: assert property (@(posedge clock) disable iff (reset)
        ((issue_alu_valid & ~alu_ready) == '0) && ((issue_mult_valid & ~mult_ready) == '0))
    else begin
        $display("an issue valid was raised toward a busy functional unit");
        $display("Result: FAILED");
        $fatal(1);
    end

    function automatic logic on_cdb(input rs_pkg::preg_tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int c = 0; c < rs_pkg::cdb_width; c++) begin
            if (cdb[c].valid && cdb[c].tag == tag) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    task automatic check_issue(input rs_pkg::issue_packet_t p, input rs_pkg::fu_class_t cls);
        int s;
        s = int'(p.seq);
        if (!live[s]) begin
            fail_run("an instruction issued that was not waiting in the station");
        end
        assert (sb_class[s] == cls) else report_value("fu_class", 32'(cls), 32'(sb_class[s]));
        assert (sb_rdy1[s] && sb_rdy2[s])
            else fail_run("an instruction issued before its sources were ready");
        assert (p.dest == sb_dest[s]) else report_value("issue.dest", 32'(p.dest), 32'(sb_dest[s]));
        assert (p.src1 == sb_tag1[s]) else report_value("issue.src1", 32'(p.src1), 32'(sb_tag1[s]));
        assert (p.src2 == sb_tag2[s]) else report_value("issue.src2", 32'(p.src2), 32'(sb_tag2[s]));
        assert (p.br_mask == sb_mask[s])
            else report_value("issue.br_mask", 32'(p.br_mask), 32'(sb_mask[s]));
        live[s] = 1'b0;
        occ     = occ - 1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model, stepped at each rising edge
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        rs_pkg::br_mask_t resolved;
        rs_pkg::br_mask_t lane_mask;
        int               s;
        logic             exp_ready;
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
        if (!reset) begin
            exp_ready = (rs_pkg::rs_depth - occ) >= rs_pkg::dispatch_width;
            assert (dispatch_ready == exp_ready)
                else report_value("dispatch_ready", 32'(dispatch_ready), 32'(exp_ready));
            for (int f = 0; f < rs_pkg::num_alu; f++) begin
                if (issue_alu_valid[f] && alu_ready[f]) begin
                    check_issue(issue_alu[f], rs_pkg::class_alu);
                end
            end
            for (int f = 0; f < rs_pkg::num_mult; f++) begin
                if (issue_mult_valid[f] && mult_ready[f]) begin
                    check_issue(issue_mult[f], rs_pkg::class_mult);
                end
            end
            resolved = br_resolve.valid ? br_resolve.br_id : '0;
            for (int i = 0; i < num_seq; i++) begin
                if (live[i]) begin
                    if (br_resolve.valid && br_resolve.squash && (sb_mask[i] & resolved) != '0) begin
                        live[i] = 1'b0;
                        occ     = occ - 1;
                    end else begin
                        sb_mask[i] = sb_mask[i] & ~resolved;
                        sb_rdy1[i] = sb_rdy1[i] | on_cdb(sb_tag1[i]);
                        sb_rdy2[i] = sb_rdy2[i] | on_cdb(sb_tag2[i]);
                    end
                end
            end
            if (dispatch_valid && dispatch_ready) begin
                lane_mask = run_mask;
                for (int l = 0; l < rs_pkg::dispatch_width; l++) begin
                    if (dispatch_bundle[l].valid) begin
                        s           = int'(dispatch_bundle[l].seq);
                        live[s]     = 1'b1;
                        occ         = occ + 1;
                        sb_class[s] = dispatch_bundle[l].fu_class;
                        sb_dest[s]  = dispatch_bundle[l].dest;
                        sb_tag1[s]  = dispatch_bundle[l].src1.tag;
                        sb_tag2[s]  = dispatch_bundle[l].src2.tag;
                        sb_rdy1[s]  = dispatch_bundle[l].src1.ready | on_cdb(sb_tag1[s]);
                        sb_rdy2[s]  = dispatch_bundle[l].src2.ready | on_cdb(sb_tag2[s]);
                        sb_mask[s]  = lane_mask & ~resolved;
                        if (dispatch_bundle[l].new_branch) begin
                            lane_mask = lane_mask | dispatch_bundle[l].br_id;
                        end
                    end
                end
                run_mask = lane_mask;
            end
            run_mask = run_mask & ~resolved;
        end
    end

    // unit readiness and broadcasts of waiting tags
    always @(negedge clock) begin
        if (!reset) begin
            alu_ready  = hold_busy ? '0 : (random_busy ? 2'($urandom) : '1);
            mult_ready = hold_busy ? '0 : (random_busy ? 1'($urandom) : '1);
            cdb        = '0;
            for (int c = 0; c < rs_pkg::cdb_width; c++) begin
                if (!cdb_hold && pending.size() > 0 && $urandom_range(1) == 1) begin
                    cdb[c].valid = 1'b1;
                    cdb[c].tag   = pending.pop_front();
                end
            end
        end
    end

    function automatic rs_pkg::dispatch_packet_t new_packet(
        input rs_pkg::fu_class_t cls,
        input logic              rdy1,
        input logic              rdy2,
        input logic              new_br,
        input rs_pkg::br_mask_t  br_id
    );
        rs_pkg::dispatch_packet_t p;
        p.valid      = 1'b1;
        p.fu_class   = cls;
        p.dest       = 6'($urandom_range(63));
        p.src1.tag   = 6'($urandom_range(63));
        p.src1.ready = rdy1;
        p.src2.tag   = 6'($urandom_range(63));
        p.src2.ready = rdy2;
        p.new_branch = new_br;
        p.br_id      = br_id;
        p.seq        = next_seq;
        next_seq     = next_seq + 1;
        return p;
    endfunction

    // called at a falling edge, returns at a falling edge
    task automatic send_pair(input rs_pkg::dispatch_packet_t p0, input rs_pkg::dispatch_packet_t p1);
        while (!dispatch_ready) begin
            @(negedge clock);
        end
        dispatch_bundle[0] = p0;
        dispatch_bundle[1] = p1;
        dispatch_valid     = 1'b1;
        @(negedge clock);
        dispatch_valid = 1'b0;
        if (!p0.src1.ready) pending.push_back(p0.src1.tag);
        if (!p0.src2.ready) pending.push_back(p0.src2.tag);
        if (!p1.src1.ready) pending.push_back(p1.src1.tag);
        if (!p1.src2.ready) pending.push_back(p1.src2.tag);
    endtask

    task automatic resolve(input logic squash, input rs_pkg::br_mask_t id);
        br_resolve.valid  = 1'b1;
        br_resolve.squash = squash;
        br_resolve.br_id  = id;
        @(negedge clock);
        br_resolve = '0;
    endtask

    task automatic wait_drain();
        while (occ != 0) begin
            @(negedge clock);
        end
    endtask

    initial begin
        void'($urandom(32'h772c));
        reset           = 1'b1;
        dispatch_valid  = 1'b0;
        dispatch_bundle = '0;
        cdb             = '0;
        br_resolve      = '0;
        alu_ready       = '1;
        mult_ready      = '1;
        hold_busy       = 1'b0;
        random_busy     = 1'b0;
        cdb_hold        = 1'b0;
        occ             = 0;
        cycles          = 0;
        next_seq        = '0;
        run_mask        = '0;
        for (int i = 0; i < num_seq; i++) begin
            live[i] = 1'b0;
        end
        repeat (5) @(negedge clock);
        reset = 1'b0;

        // idle after reset
        repeat (3) begin
            @(negedge clock);
            assert (dispatch_ready && issue_alu_valid == '0 && issue_mult_valid == '0)
                else fail_run("station not idle after reset");
        end

        // ready sources issue straight away
        for (int k = 0; k < 4; k++) begin
            send_pair(new_packet(rs_pkg::fu_class_t'(k % 2), 1, 1, 0, '0),
                      new_packet(rs_pkg::class_alu, 1, 1, 0, '0));
        end
        wait_drain();

        // sources held back until broadcast
        cdb_hold = 1'b1;
        send_pair(new_packet(rs_pkg::class_alu, 0, 1, 0, '0),
                  new_packet(rs_pkg::class_mult, 1, 0, 0, '0));
        repeat (10) @(negedge clock);
        cdb_hold = 1'b0;
        wait_drain();

        // random busy units and random readiness
        random_busy = 1'b1;
        for (int k = 0; k < 40; k++) begin
            send_pair(new_packet(rs_pkg::fu_class_t'($urandom_range(1)),
                                 $urandom_range(3) != 0, $urandom_range(3) != 0, 0, '0),
                      new_packet(rs_pkg::fu_class_t'($urandom_range(1)),
                                 $urandom_range(3) != 0, $urandom_range(3) != 0, 0, '0));
        end
        random_busy = 1'b0;
        wait_drain();

        // fill the station with all units busy
        hold_busy = 1'b1;
        @(negedge clock);
        for (int k = 0; k < 4; k++) begin
            send_pair(new_packet(rs_pkg::class_alu, 1, 1, 0, '0),
                      new_packet(rs_pkg::class_mult, 1, 1, 0, '0));
        end
        assert (!dispatch_ready) else fail_run("dispatch_ready stayed high with the station full");
        hold_busy = 1'b0;
        wait_drain();

        //////////////////////////////////////////////////////////////////
        // branch squash and clear
        //////////////////////////////////////////////////////////////////
        hold_busy = 1'b1;
        @(negedge clock);
        send_pair(new_packet(rs_pkg::class_alu, 1, 1, 1, 4'b0001),
                  new_packet(rs_pkg::class_mult, 1, 1, 0, '0));
        send_pair(new_packet(rs_pkg::class_alu, 1, 1, 0, '0),
                  new_packet(rs_pkg::class_alu, 1, 1, 1, 4'b0010));
        resolve(1'b1, 4'b0001);
        resolve(1'b0, 4'b0010);
        send_pair(new_packet(rs_pkg::class_alu, 1, 1, 1, 4'b0100),
                  new_packet(rs_pkg::class_mult, 1, 1, 0, '0));
        resolve(1'b0, 4'b0100);
        hold_busy = 1'b0;
        wait_drain();
        send_pair(new_packet(rs_pkg::class_alu, 1, 1, 0, '0),
                  new_packet(rs_pkg::class_mult, 1, 1, 0, '0));
        wait_drain();

        repeat (2) @(negedge clock);
        if (occ == 0 && run_mask == '0) begin
            $display("Result: PASSED");
        end else begin
            fail_run("instructions left over or branches unresolved at the end");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rs_top.sv
`timescale 1ns/100ps
`default_nettype none

module rs_top (
    input  wire logic                                                  clock,
    input  wire logic                                                  reset,
    input  wire logic                                                  dispatch_valid,
    input  wire rs_pkg::dispatch_packet_t [rs_pkg::dispatch_width-1:0] dispatch_bundle,
    output      logic                                                  dispatch_ready,
    input  wire rs_pkg::cdb_packet_t [rs_pkg::cdb_width-1:0]           cdb,
    input  wire rs_pkg::br_resolve_t                                   br_resolve,
    input  wire logic [rs_pkg::num_alu-1:0]                            alu_ready,
    output      logic [rs_pkg::num_alu-1:0]                            issue_alu_valid,
    output      rs_pkg::issue_packet_t [rs_pkg::num_alu-1:0]           issue_alu,
    input  wire logic [rs_pkg::num_mult-1:0]                           mult_ready,
    output      logic [rs_pkg::num_mult-1:0]                           issue_mult_valid,
    output      rs_pkg::issue_packet_t [rs_pkg::num_mult-1:0]          issue_mult
);

    logic [rs_pkg::dispatch_width-1:0][rs_pkg::rs_depth-1:0] write_enable_bus;
    rs_pkg::rs_entry_t [rs_pkg::dispatch_width-1:0]         write_entries;
    rs_pkg::rs_entry_t [rs_pkg::rs_depth-1:0]               entries;
    logic [rs_pkg::rs_depth-1:0] free_entries;
    logic [rs_pkg::rs_depth-1:0] alu_req;
    logic [rs_pkg::rs_depth-1:0] mult_req;
    logic [rs_pkg::rs_depth-1:0] alu_granted;
    logic [rs_pkg::rs_depth-1:0] mult_granted;

    rs_dispatch dispatch_i (
        .clock           (clock),
        .reset           (reset),
        .dispatch_valid  (dispatch_valid),
        .dispatch_bundle (dispatch_bundle),
        .dispatch_ready  (dispatch_ready),
        .br_resolve      (br_resolve),
        .free_entries    (free_entries),
        .write_enable_bus(write_enable_bus),
        .write_entries   (write_entries)
    );

    rs_entry_array entry_array_i (
        .clock           (clock),
        .reset           (reset),
        .write_enable_bus(write_enable_bus),
        .write_entries   (write_entries),
        .cdb             (cdb),
        .br_resolve      (br_resolve),
        .issued_entries  (alu_granted | mult_granted),
        .free_entries    (free_entries),
        .alu_req         (alu_req),
        .mult_req        (mult_req),
        .entries         (entries)
    );

    rs_issue_select #(.NUM_FU(rs_pkg::num_alu)) alu_select (
        .inst_req   (alu_req),
        .fu_ready   (alu_ready),
        .entries    (entries),
        .issue_valid(issue_alu_valid),
        .issue      (issue_alu),
        .granted    (alu_granted)
    );

    rs_issue_select #(.NUM_FU(rs_pkg::num_mult)) mult_select (
        .inst_req   (mult_req),
        .fu_ready   (mult_ready),
        .entries    (entries),
        .issue_valid(issue_mult_valid),
        .issue      (issue_mult),
        .granted    (mult_granted)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rs_tb -f compile.f -o rs_sim

out=$(./obj_dir/rs_sim) || true
echo "$out"

echo "$out" | grep -q "^Result: PASSED$"
